/* Makefile */
VERILATOR ?= verilator
TOP       ?= tbOffChipItf
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1 || true
	cat $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* common/itfPkg.sv */
package itfPkg;

`include "itf_defs.svh"

    // Data widths
    typedef logic [`ITF_PAD_W-1:0]  padWord_t;
    typedef logic [`ITF_SRAM_W-1:0] sramWord_t;

    // Addresses and counts
    typedef logic [`ITF_ADDR_W-1:0] bufAddr_t;
    typedef logic [`ITF_NUM_W-1:0]  reqNum_t;
    typedef logic [`ITF_DRAM_W-1:0] dramAddr_t;
    typedef logic [$clog2(`ITF_NUM_PORT)-1:0] portIdx_t;

    // Command beat sent ahead of every transfer
    // dir is set for read ports (data leaves the chip)
    typedef struct packed {
        logic      dir;
        portIdx_t  port;
        reqNum_t   num;
        dramAddr_t dramAddr;
    } itfCmd_t;

    // Request held by one buffer port
    typedef struct packed {
        reqNum_t   num;
        bufAddr_t  bufAddr;
        dramAddr_t dramBase;
    } portReq_t;

    // Transfer FSM
    typedef enum logic [2:0] {
        Idle,
        Cmd,
        In,
        Out,
        Fnh
    } itfState_t;

endpackage

/* common/itf_defs.svh */
`ifndef ITF_DEFS_SVH
`define ITF_DEFS_SVH

// Pad bus and global buffer widths
`define ITF_PAD_W       32
`define ITF_SRAM_W      64

// Buffer ports
// Write ports come first, read ports follow
`define ITF_NUM_WR      2
`define ITF_NUM_RD      2
`define ITF_NUM_PORT    4

// Address and count widths
`define ITF_ADDR_W      10
`define ITF_NUM_W       8

// DRAM address field of the command word
`define ITF_DRAM_W      21

`endif

/* itf/itfCtrl.sv */
`timescale 1ns/1ps

`include "itf_defs.svh"

module itfCtrl (
    input  logic                      clk,
    input  logic                      rst_n,
    // Arbiter side
    input  logic                      grantVld,
    input  itfPkg::portIdx_t          grantIdx,
    output logic                      arbTake,
    // Request side
    input  itfPkg::portReq_t          portReq [`ITF_NUM_PORT],
    output logic [`ITF_NUM_PORT-1:0]  portDone,
    // Pad output
    output itfPkg::padWord_t          padOut,
    output logic                      padOutVld,
    output logic                      padOutLast,
    output logic                      padOe,
    input  logic                      padOutRdy,
    // Packer side
    input  logic                      padInVld,
    output logic                      packVld,
    input  itfPkg::sramWord_t         packDat,
    input  logic                      packWordVld,
    input  logic                      packLast,
    output logic                      packRdy,
    // Buffer write
    output itfPkg::sramWord_t         wrDat,
    output itfPkg::bufAddr_t          wrAddr,
    output logic                      wrVld,
    output itfPkg::portIdx_t          wrPort,
    input  logic                      wrRdy,
    // Buffer read
    output itfPkg::bufAddr_t          rdAddr,
    output logic                      rdAddrVld,
    output itfPkg::portIdx_t          rdPort,
    input  logic                      rdAddrRdy,
    input  itfPkg::sramWord_t         rdDat,
    input  logic                      rdDatVld,
    output logic                      rdDatRdy,
    // Splitter side
    output logic                      splitVld,
    output itfPkg::sramWord_t         splitDat,
    output logic                      splitLast,
    input  logic                      splitRdy,
    input  itfPkg::padWord_t          splitOut,
    input  logic                      splitOutVld,
    input  logic                      splitOutLast,
    output logic                      splitOutRdy
);

    itfPkg::itfState_t state;
    itfPkg::itfState_t nxtState;

    // Latched request of the served port
    itfPkg::portReq_t  curReq;
    itfPkg::portIdx_t  curPort;
    itfPkg::itfCmd_t   cmdWord;

    itfPkg::reqNum_t   wrCnt;
    itfPkg::reqNum_t   issueCnt;
    itfPkg::reqNum_t   retCnt;

    logic isCmd;
    logic isIn;
    logic isOut;
    logic padFire;
    logic wrFire;
    logic rdAddrFire;
    logic retFire;

    assign isCmd = (state == itfPkg::Cmd);
    assign isIn  = (state == itfPkg::In);
    assign isOut = (state == itfPkg::Out);

    assign padFire    = padOutVld & padOutRdy;
    assign wrFire     = wrVld & wrRdy;
    assign rdAddrFire = rdAddrVld & rdAddrRdy;
    assign retFire    = rdDatVld & rdDatRdy;

    // =================================================================
    // Transfer FSM
    // =================================================================

    // Grant taken on the Idle to Cmd step
    assign arbTake = (state == itfPkg::Idle) & grantVld;

    always_comb begin
        nxtState = state;
        case (state)
            itfPkg::Idle: begin
                if (grantVld) begin
                    nxtState = itfPkg::Cmd;
                end
            end
            // Command beat accepted, direction picks the data phase
            itfPkg::Cmd: begin
                if (padFire) begin
                    nxtState = cmdWord.dir ? itfPkg::Out : itfPkg::In;
                end
            end
            // Final packed word written
            itfPkg::In: begin
                if (wrFire && packLast) begin
                    nxtState = itfPkg::Fnh;
                end
            end
            // Final pad beat accepted
            itfPkg::Out: begin
                if (padFire && splitOutLast) begin
                    nxtState = itfPkg::Fnh;
                end
            end
            itfPkg::Fnh: nxtState = itfPkg::Idle;
            default:     nxtState = itfPkg::Idle;
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= itfPkg::Idle;
            curPort <= '0;
        end else begin
            state <= nxtState;
            if (arbTake) begin
                curPort <= grantIdx;
            end
        end
    end

    // Request fields held for the whole transfer
    always_ff @(posedge clk) begin
        if (arbTake) begin
            curReq <= portReq[grantIdx];
        end
    end

    // =================================================================
    // Command word and counters
    // =================================================================

    always_comb begin
        cmdWord.dir      = (curPort >= itfPkg::portIdx_t'(`ITF_NUM_WR));
        cmdWord.port     = curPort;
        cmdWord.num      = curReq.num;
        // DRAM start is base plus buffer address, wraps at 21 bits
        cmdWord.dramAddr = itfPkg::dramAddr_t'(curReq.dramBase
                         + itfPkg::dramAddr_t'(curReq.bufAddr));
    end

    // Write offset, read issue and read return counts
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wrCnt    <= '0;
            issueCnt <= '0;
            retCnt   <= '0;
        end else if (arbTake) begin
            wrCnt    <= '0;
            issueCnt <= '0;
            retCnt   <= '0;
        end else begin
            if (wrFire) begin
                wrCnt <= wrCnt + 1'b1;
            end
            if (rdAddrFire) begin
                issueCnt <= issueCnt + 1'b1;
            end
            if (retFire) begin
                retCnt <= retCnt + 1'b1;
            end
        end
    end

    // =================================================================
    // Data steering
    // =================================================================

    // Pad input into the packer, only during In
    assign packVld = isIn & padInVld;
    assign packRdy = isIn & wrRdy;

    // Packed words to the buffer write port
    assign wrDat  = packDat;
    assign wrVld  = isIn & packWordVld;
    assign wrAddr = curReq.bufAddr + itfPkg::bufAddr_t'(wrCnt);
    assign wrPort = curPort;

    // Read addresses run ahead of returned data, stop after num
    assign rdAddrVld = isOut && (issueCnt != curReq.num);
    assign rdAddr    = curReq.bufAddr + itfPkg::bufAddr_t'(issueCnt);
    assign rdPort    = curPort;

    // Returned words into the splitter
    assign splitVld  = isOut & rdDatVld;
    assign splitDat  = rdDat;
    assign splitLast = (retCnt == itfPkg::reqNum_t'(curReq.num - 1'b1));
    assign rdDatRdy  = isOut & splitRdy;

    // Pad output, command beat first then split beats
    // Command is its own last beat
    assign padOut      = isCmd ? itfPkg::padWord_t'(cmdWord) : splitOut;
    assign padOutVld   = isCmd | (isOut & splitOutVld);
    assign padOutLast  = isCmd | (isOut & splitOutLast);
    assign padOe       = isCmd | isOut;
    assign splitOutRdy = isOut & padOutRdy;

    // One-cycle done strobe to the served port
    always_comb begin
        portDone = '0;
        if (state == itfPkg::Fnh) begin
            portDone[curPort] = 1'b1;
        end
    end

endmodule

/* list.f */
+incdir+common
common/itfPkg.sv
src/rrArbiter.sv
src/sipoPack.sv
src/pisoSplit.sv
itf/itfCtrl.sv
src/offChipItf.sv
test/offChipItf_sva.sv
test/tbOffChipItf.sv

/* src/offChipItf.sv */
`timescale 1ns/1ps

`include "itf_defs.svh"

module offChipItf (
    input  logic                      clk,
    input  logic                      rst_n,
    // Port requests
    input  logic [`ITF_NUM_PORT-1:0]  portReqVld,
    input  itfPkg::portReq_t          portReq [`ITF_NUM_PORT],
    output logic [`ITF_NUM_PORT-1:0]  portDone,
    // Pad output
    output itfPkg::padWord_t          padOut,
    output logic                      padOutVld,
    output logic                      padOutLast,
    output logic                      padOe,
    input  logic                      padOutRdy,
    // Pad input
    input  itfPkg::padWord_t          padIn,
    input  logic                      padInVld,
    input  logic                      padInLast,
    output logic                      padInRdy,
    // Buffer write
    output itfPkg::sramWord_t         wrDat,
    output itfPkg::bufAddr_t          wrAddr,
    output logic                      wrVld,
    output itfPkg::portIdx_t          wrPort,
    input  logic                      wrRdy,
    // Buffer read
    output itfPkg::bufAddr_t          rdAddr,
    output logic                      rdAddrVld,
    output itfPkg::portIdx_t          rdPort,
    input  logic                      rdAddrRdy,
    input  itfPkg::sramWord_t         rdDat,
    input  logic                      rdDatVld,
    output logic                      rdDatRdy
);

    // Arbiter to controller
    logic              grantVld;
    itfPkg::portIdx_t  grantIdx;
    logic              arbTake;

    // Packer
    logic              packVld;
    itfPkg::sramWord_t packDat;
    logic              packWordVld;
    logic              packLast;
    logic              packRdy;

    // Splitter
    logic              splitVld;
    itfPkg::sramWord_t splitDat;
    logic              splitLast;
    logic              splitRdy;
    itfPkg::padWord_t  splitOut;
    logic              splitOutVld;
    logic              splitOutLast;
    logic              splitOutRdy;

    rrArbiter #(
        .NUM (`ITF_NUM_PORT)
    ) arb_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .req      (portReqVld),
        .take     (arbTake),
        .grantVld (grantVld),
        .grantIdx (grantIdx)
    );

    itfCtrl ctrl_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .grantVld     (grantVld),
        .grantIdx     (grantIdx),
        .arbTake      (arbTake),
        .portReq      (portReq),
        .portDone     (portDone),
        .padOut       (padOut),
        .padOutVld    (padOutVld),
        .padOutLast   (padOutLast),
        .padOe        (padOe),
        .padOutRdy    (padOutRdy),
        .padInVld     (padInVld),
        .packVld      (packVld),
        .packDat      (packDat),
        .packWordVld  (packWordVld),
        .packLast     (packLast),
        .packRdy      (packRdy),
        .wrDat        (wrDat),
        .wrAddr       (wrAddr),
        .wrVld        (wrVld),
        .wrPort       (wrPort),
        .wrRdy        (wrRdy),
        .rdAddr       (rdAddr),
        .rdAddrVld    (rdAddrVld),
        .rdPort       (rdPort),
        .rdAddrRdy    (rdAddrRdy),
        .rdDat        (rdDat),
        .rdDatVld     (rdDatVld),
        .rdDatRdy     (rdDatRdy),
        .splitVld     (splitVld),
        .splitDat     (splitDat),
        .splitLast    (splitLast),
        .splitRdy     (splitRdy),
        .splitOut     (splitOut),
        .splitOutVld  (splitOutVld),
        .splitOutLast (splitOutLast),
        .splitOutRdy  (splitOutRdy)
    );

    // Pad beats to buffer words, ready gated through packVld
    sipoPack #(
        .IN_W  (`ITF_PAD_W),
        .OUT_W (`ITF_SRAM_W)
    ) pack_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .inDat   (padIn),
        .inVld   (packVld),
        .inLast  (padInLast),
        .inRdy   (padInRdy),
        .outDat  (packDat),
        .outVld  (packWordVld),
        .outLast (packLast),
        .outRdy  (packRdy)
    );

    // Buffer words to pad beats
    pisoSplit #(
        .IN_W  (`ITF_SRAM_W),
        .OUT_W (`ITF_PAD_W)
    ) split_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .inDat   (splitDat),
        .inVld   (splitVld),
        .inLast  (splitLast),
        .inRdy   (splitRdy),
        .outDat  (splitOut),
        .outVld  (splitOutVld),
        .outLast (splitOutLast),
        .outRdy  (splitOutRdy)
    );

endmodule

/* src/pisoSplit.sv */
`timescale 1ns/1ps

module pisoSplit #(
    parameter int IN_W  = 64,
    parameter int OUT_W = 32
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [IN_W-1:0]  inDat,
    input  logic             inVld,
    input  logic             inLast,
    output logic             inRdy,
    output logic [OUT_W-1:0] outDat,
    output logic             outVld,
    output logic             outLast,
    input  logic             outRdy
);

    localparam int SLOTS = IN_W / OUT_W;
    localparam int CNT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    logic [IN_W-1:0]  wordReg;
    logic [CNT_W-1:0] slotCnt;
    logic             full;
    logic             lastReg;
    logic             inFire;
    logic             outFire;
    logic             lastSlice;

    // Load only when empty
    assign inRdy     = ~full;
    assign inFire    = inVld & inRdy;
    assign outFire   = full & outRdy;
    assign lastSlice = (slotCnt == CNT_W'(SLOTS - 1));

    // Low slice leaves first, the rest shifts down
    always_ff @(posedge clk) begin
        if (inFire) begin
            wordReg <= inDat;
        end else if (outFire) begin
            wordReg <= wordReg >> OUT_W;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slotCnt <= '0;
            full    <= 1'b0;
            lastReg <= 1'b0;
        end else if (inFire) begin
            full    <= 1'b1;
            slotCnt <= '0;
            lastReg <= inLast;
        end else if (outFire) begin
            // Word drained after its final slice
            if (lastSlice) begin
                full    <= 1'b0;
                slotCnt <= '0;
            end else begin
                slotCnt <= slotCnt + 1'b1;
            end
        end
    end

    assign outDat  = wordReg[OUT_W-1:0];
    assign outVld  = full;
    // Transfer end only on the final slice of a last word
    assign outLast = lastReg & lastSlice;

endmodule

/* src/rrArbiter.sv */
`timescale 1ns/1ps

module rrArbiter #(
    parameter int NUM = 4
) (
    input  logic               clk,
    input  logic               rst_n,
    input  logic [NUM-1:0]     req,
    input  logic               take,
    output logic               grantVld,
    output itfPkg::portIdx_t   grantIdx
);

    // Index of the last served requester
    itfPkg::portIdx_t lastPtr;

    // Circular search starting one above lastPtr
    // Walk offsets downwards so the nearest request wins
    always_comb begin
        int cand;
        grantVld = 1'b0;
        grantIdx = lastPtr;
        cand = 0;
        for (int off = NUM; off > 0; off--) begin
            cand = (int'(lastPtr) + off) % NUM;
            if (req[cand]) begin
                grantVld = 1'b1;
                grantIdx = itfPkg::portIdx_t'(cand);
            end
        end
    end

    // Pointer moves only when the controller takes the grant
    // Starting at NUM-1 makes port 0 the first choice
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            lastPtr <= itfPkg::portIdx_t'(NUM - 1);
        end else if (take && grantVld) begin
            lastPtr <= grantIdx;
        end
    end

endmodule

/* src/sipoPack.sv */
`timescale 1ns/1ps

module sipoPack #(
    parameter int IN_W  = 32,
    parameter int OUT_W = 64
) (
    input  logic             clk,
    input  logic             rst_n,
    input  logic [IN_W-1:0]  inDat,
    input  logic             inVld,
    input  logic             inLast,
    output logic             inRdy,
    output logic [OUT_W-1:0] outDat,
    output logic             outVld,
    output logic             outLast,
    input  logic             outRdy
);

    localparam int SLOTS = OUT_W / IN_W;
    localparam int CNT_W = (SLOTS > 1) ? $clog2(SLOTS) : 1;

    logic [OUT_W-1:0] shiftReg;
    logic [CNT_W-1:0] slotCnt;
    logic             full;
    logic             lastReg;
    logic             inFire;
    logic             wordDone;

    // Ready follows valid, so an idle input leaves ready low
    // No beats taken while a full word waits downstream
    assign inRdy    = inVld & ~full;
    assign inFire   = inVld & inRdy;
    assign wordDone = inFire && (slotCnt == CNT_W'(SLOTS - 1));

    // Beats enter at the top and shift down
    // First beat ends up in the low slot
    always_ff @(posedge clk) begin
        if (inFire) begin
            shiftReg <= {inDat, shiftReg[OUT_W-1:IN_W]};
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            slotCnt <= '0;
            full    <= 1'b0;
            lastReg <= 1'b0;
        end else begin
            if (inFire) begin
                slotCnt <= wordDone ? '0 : slotCnt + 1'b1;
            end
            // Last flag comes from the completing beat
            if (wordDone) begin
                full    <= 1'b1;
                lastReg <= inLast;
            end else if (outVld && outRdy) begin
                full <= 1'b0;
            end
        end
    end

    assign outDat  = shiftReg;
    assign outVld  = full;
    assign outLast = lastReg;

endmodule

/* test/offChipItf_sva.sv */
`timescale 1ns/1ps

`include "itf_defs.svh"

module offChipItf_sva (
    input logic                      clk,
    input logic                      rst_n,
    input logic [`ITF_NUM_PORT-1:0]  portDone,
    input itfPkg::padWord_t          padOut,
    input logic                      padOutVld,
    input logic                      padOutRdy,
    input logic                      padOe,
    input logic                      padInRdy,
    input logic                      wrVld,
    input logic                      rdAddrVld,
    input logic                      rdDatRdy
);

    // Pad driver enabled whenever a beat is offered
    assert property (@(posedge clk) disable iff (!rst_n) padOutVld |-> padOe)
        else $error("padOutVld high while padOe low");

    // Offered beat holds until accepted
    assert property (@(posedge clk) disable iff (!rst_n)
        padOutVld && !padOutRdy |=> padOutVld && $stable(padOut))
        else $error("pad output beat changed before handshake");

    // Buffer write and read address never overlap
    assert property (@(posedge clk) disable iff (!rst_n) !(wrVld && rdAddrVld))
        else $error("wrVld and rdAddrVld both high");

    // At most one done strobe
    assert property (@(posedge clk) disable iff (!rst_n) $onehot0(portDone))
        else $error("portDone not one-hot");

    // Control outputs quiet in reset
    assert property (@(posedge clk) !rst_n |-> !(padOutVld || padOe || padInRdy
        || wrVld || rdAddrVld || rdDatRdy || (|portDone)))
        else $error("control output high during reset");

endmodule

bind offChipItf offChipItf_sva sva_i (
    .clk       (clk),
    .rst_n     (rst_n),
    .portDone  (portDone),
    .padOut    (padOut),
    .padOutVld (padOutVld),
    .padOutRdy (padOutRdy),
    .padOe     (padOe),
    .padInRdy  (padInRdy),
    .wrVld     (wrVld),
    .rdAddrVld (rdAddrVld),
    .rdDatRdy  (rdDatRdy)
);

/* test/tbOffChipItf.sv */
`timescale 1ns/1ps

`include "itf_defs.svh"

module tbOffChipItf;

    localparam int NUM_XFER = 40;
    // Transfers x max words x beats per word x slack
    localparam int LIMIT    = NUM_XFER * 8 * 2 * 10;
    localparam int WAIT_CMD = 0;
    localparam int RD_MODE  = 1;
    localparam int WR_MODE  = 2;

    logic                      clk;
    logic                      rst_n;
    logic [`ITF_NUM_PORT-1:0]  portReqVld;
    itfPkg::portReq_t          portReq [`ITF_NUM_PORT];
    logic [`ITF_NUM_PORT-1:0]  portDone;
    itfPkg::padWord_t          padOut;
    logic                      padOutVld;
    logic                      padOutLast;
    logic                      padOe;
    logic                      padOutRdy;
    itfPkg::padWord_t          padIn;
    logic                      padInVld;
    logic                      padInLast;
    logic                      padInRdy;
    itfPkg::sramWord_t         wrDat;
    itfPkg::bufAddr_t          wrAddr;
    logic                      wrVld;
    itfPkg::portIdx_t          wrPort;
    logic                      wrRdy;
    itfPkg::bufAddr_t          rdAddr;
    logic                      rdAddrVld;
    itfPkg::portIdx_t          rdPort;
    logic                      rdAddrRdy;
    itfPkg::sramWord_t         rdDat;
    logic                      rdDatVld;
    logic                      rdDatRdy;

    offChipItf dut_i (.*);

    // Buffer model keyed by port * 1024 + address
    itfPkg::sramWord_t bufMem [int];

    // Expected streams of the current transfer
    itfPkg::padWord_t  inBeats [$];
    itfPkg::sramWord_t expWr [$];
    itfPkg::padWord_t  expOut [$];
    itfPkg::sramWord_t retDat [$];
    int                retTime [$];

    itfPkg::portReq_t  curReq;
    itfPkg::portIdx_t  curPort;
    itfPkg::portIdx_t  rrPtr;
    itfPkg::itfCmd_t   expCmd;
    itfPkg::sramWord_t rdWord;
    logic [`ITF_NUM_PORT-1:0] prevReq;
    int gap [`ITF_NUM_PORT];
    int mode;
    int cmdSeen;
    int wrK;
    int outK;
    int issueK;
    int doneCnt;
    int cycles;

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ==================================================================
    // Checking helpers
    // ==================================================================

    task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
        if (got !== exp) begin
            $display("Error: %s got 0x%0h expected 0x%0h", name, got, exp);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    task automatic failNow(input string msg);
        $display("%s", msg);
        $display("Simulation failed");
        $fatal(1);
    endtask

    function automatic itfPkg::portReq_t newReq();
        itfPkg::portReq_t r;
        r.num      = itfPkg::reqNum_t'(1 + $urandom % 8);
        r.bufAddr  = itfPkg::bufAddr_t'($urandom);
        r.dramBase = itfPkg::dramAddr_t'($urandom);
        return r;
    endfunction

    // Unwritten words depend on port and full address
    function automatic itfPkg::sramWord_t readBuf(input int p, input itfPkg::bufAddr_t a);
        int key;
        key = p * 1024 + int'(a);
        if (bufMem.exists(key)) begin
            return bufMem[key];
        end
        return {8'hB0 + 8'(p), 14'(a), 10'(a), 32'(a) * 32'h9E3779B1};
    endfunction

    // Next requester after the last grant with wraparound
    function automatic itfPkg::portIdx_t nextGrant(input logic [3:0] req,
                                                   input itfPkg::portIdx_t ptr);
        itfPkg::portIdx_t idx;
        for (int i = 1; i <= `ITF_NUM_PORT; i++) begin
            idx = itfPkg::portIdx_t'((int'(ptr) + i) % `ITF_NUM_PORT);
            if (req[idx]) begin
                return idx;
            end
        end
        return ptr;
    endfunction

    function automatic itfPkg::itfCmd_t buildCmd(input itfPkg::portIdx_t p,
                                                 input itfPkg::portReq_t r);
        itfPkg::itfCmd_t c;
        c.dir      = (int'(p) >= `ITF_NUM_WR);
        c.port     = p;
        c.num      = r.num;
        c.dramAddr = itfPkg::dramAddr_t'(r.dramBase + itfPkg::dramAddr_t'(r.bufAddr));
        return c;
    endfunction

    // ==================================================================
    // Reset and initial stimulus
    // ==================================================================

    initial begin
        void'($urandom(32'h10d));
        rst_n      = 1'b0;
        padOutRdy  = 1'b0;
        padIn      = '0;
        padInVld   = 1'b0;
        padInLast  = 1'b0;
        wrRdy      = 1'b0;
        rdAddrRdy  = 1'b0;
        rdDat      = '0;
        rdDatVld   = 1'b0;
        rrPtr      = itfPkg::portIdx_t'(`ITF_NUM_PORT - 1);
        prevReq    = '0;
        mode       = WAIT_CMD;
        cmdSeen    = 0;
        doneCnt    = 0;
        cycles     = 0;
        // All four ports request from the start
        portReqVld = '1;
        for (int p = 0; p < `ITF_NUM_PORT; p++) begin
            portReq[p] = newReq();
            gap[p]     = 0;
        end
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    end

    // ==================================================================
    // Per-cycle models and checks
    // ==================================================================

    always @(posedge clk) begin
        if (rst_n) begin
            cycles++;
            if (cycles >= LIMIT) begin
                failNow("Timeout: transfers did not complete within the cycle limit");
            end

            // Done strobe closes the transfer
            if (|portDone) begin
                if (mode == WAIT_CMD) begin
                    failNow("portDone pulsed with no transfer in progress");
                end
                checkEq("portDone", 64'(portDone), 64'(1 << curPort));
                if (mode == WR_MODE) begin
                    checkEq("write count", 64'(wrK), 64'(curReq.num));
                end else begin
                    checkEq("read beats", 64'(outK), 64'(2 * curReq.num));
                end
                mode    = WAIT_CMD;
                cmdSeen = 0;
                doneCnt++;
            end

            // Requesters re-arm after a random gap
            for (int p = 0; p < `ITF_NUM_PORT; p++) begin
                if (portDone[p]) begin
                    portReqVld[p] <= 1'b0;
                    gap[p] = $urandom % 6;
                end else if (!portReqVld[p]) begin
                    if (gap[p] == 0) begin
                        portReq[p]    <= newReq();
                        portReqVld[p] <= 1'b1;
                    end else begin
                        gap[p]--;
                    end
                end
            end

            // First command cycle uses the request levels of the Idle cycle
            if (padOutVld && mode == WAIT_CMD && cmdSeen == 0) begin
                if (prevReq == '0) begin
                    failNow("Command issued with no port requesting");
                end
                curPort = nextGrant(prevReq, rrPtr);
                rrPtr   = curPort;
                curReq  = portReq[curPort];
                expCmd  = buildCmd(curPort, curReq);
                cmdSeen = 1;
            end

            // Pad driver on for the command beat and read data only
            checkEq("padOe", 64'(padOe),
                    64'(mode == RD_MODE || (mode == WAIT_CMD && cmdSeen == 1)));

            // Pad output beats
            if (padOutVld && padOutRdy) begin
                if (mode == WAIT_CMD) begin
                    checkEq("padOut (command)", 64'(padOut), 64'(expCmd));
                    checkEq("padOutLast (command)", 64'(padOutLast), 64'd1);
                    wrK    = 0;
                    outK   = 0;
                    issueK = 0;
                    if (expCmd.dir) begin
                        // Low half leaves first
                        for (int k = 0; k < int'(curReq.num); k++) begin
                            rdWord = readBuf(curPort,
                                curReq.bufAddr + itfPkg::bufAddr_t'(k));
                            expOut.push_back(rdWord[31:0]);
                            expOut.push_back(rdWord[63:32]);
                        end
                        mode = RD_MODE;
                    end else begin
                        for (int k = 0; k < int'(curReq.num); k++) begin
                            expWr.push_back({$urandom, $urandom});
                            inBeats.push_back(expWr[k][31:0]);
                            inBeats.push_back(expWr[k][63:32]);
                        end
                        mode = WR_MODE;
                    end
                end else if (mode == RD_MODE) begin
                    if (expOut.size() == 0) begin
                        failNow("Extra pad output beat after the read transfer ended");
                    end
                    checkEq("padOut", 64'(padOut), 64'(expOut.pop_front()));
                    checkEq("padOutLast", 64'(padOutLast),
                            64'(outK == 2 * int'(curReq.num) - 1));
                    outK++;
                end else begin
                    failNow("Pad output beat during a write transfer");
                end
            end

            // Buffer writes
            if (wrVld && wrRdy) begin
                if (mode != WR_MODE || expWr.size() == 0) begin
                    failNow("Unexpected buffer write");
                end
                checkEq("wrPort", 64'(wrPort), 64'(curPort));
                checkEq("wrAddr", 64'(wrAddr),
                        64'(itfPkg::bufAddr_t'(curReq.bufAddr + wrK)));
                checkEq("wrDat", wrDat, expWr.pop_front());
                bufMem[int'(wrPort) * 1024 + int'(wrAddr)] = wrDat;
                wrK++;
            end

            // Read address issue queues data with a random delay
            if (rdAddrVld && rdAddrRdy) begin
                if (mode != RD_MODE) begin
                    failNow("Unexpected buffer read address");
                end
                checkEq("rdPort", 64'(rdPort), 64'(curPort));
                checkEq("rdAddr", 64'(rdAddr),
                        64'(itfPkg::bufAddr_t'(curReq.bufAddr + issueK)));
                retDat.push_back(readBuf(curPort, rdAddr));
                retTime.push_back(cycles + 1 + int'($urandom % 4));
                issueK++;
            end

            // Read data return in issue order
            if (rdDatVld && rdDatRdy) begin
                void'(retDat.pop_front());
                void'(retTime.pop_front());
            end
            if (!rdDatVld || rdDatRdy) begin
                if (retDat.size() > 0 && retTime[0] <= cycles) begin
                    rdDat    <= retDat[0];
                    rdDatVld <= 1'b1;
                end else begin
                    rdDatVld <= 1'b0;
                end
            end

            // Pad input beats with random gaps
            if (padInVld && padInRdy) begin
                void'(inBeats.pop_front());
            end
            if (!padInVld || padInRdy) begin
                if (inBeats.size() > 0 && ($urandom % 4) != 0) begin
                    padIn     <= inBeats[0];
                    padInLast <= (inBeats.size() == 1);
                    padInVld  <= 1'b1;
                end else begin
                    padInVld  <= 1'b0;
                end
            end

            // Random back-pressure
            padOutRdy <= ($urandom % 4) != 0;
            wrRdy     <= ($urandom % 4) != 0;
            rdAddrRdy <= ($urandom % 4) != 0;

            prevReq = portReqVld;

            if (doneCnt == NUM_XFER) begin
                $display("Simulation passed");
                $finish;
            end
        end
    end

endmodule
